//--- verilog/hisPkg.sv
package hisPkg;

    // histogram geometry
    localparam int numBins    = 32;   // fine mode, one bin per time code
    localparam int coarseBins = 16;   // coarse mode, code pairs merged

    // acquisition window length in clock cycles
    localparam int acqCycles  = 200;

    // a bin stops counting here
    localparam int countMax   = 63;

    // bin index or raw time code
    typedef logic [4:0] binT;

    // bin count, wide enough for countMax
    typedef logic [5:0] countT;

    // pixel index, wraps after 8 pixels
    typedef logic [2:0] pixelT;

    // one bin of the scan stream, also used for the peak
    typedef struct packed {
        pixelT pixel;
        binT   bin;
        countT count;
    } binReportT;

    // histogram sequencing
    typedef enum logic [1:0] {
        accum,   // window open, hits counted
        scan,    // one bin read per cycle
        clear    // flags dropped, next pixel
    } hisStateT;

endpackage

//--- verilog/acqTimer.sv
`timescale 1ns/100ps

module acqTimer (
    input  logic clk,
    input  logic res,
    input  logic run,        // high while the window is open
    output logic windowEnd   // last cycle of the window
);

    logic [7:0] cycleCount;
    logic       lastCycle;

    // window length only lives here
    assign lastCycle = (cycleCount == 8'(hisPkg::acqCycles - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            cycleCount <= '0;
        end else if (!run) begin
            cycleCount <= '0;          // restart for the next window
        end else if (lastCycle) begin
            cycleCount <= '0;
        end else begin
            cycleCount <= cycleCount + 8'd1;
        end
    end

    // only meaningful while counting
    assign windowEnd = run && lastCycle;

endmodule

//--- verilog/hisControl.sv
`timescale 1ns/100ps

module hisControl (
    input  logic          clk,
    input  logic          res,
    input  logic          coarse,        // mode request for the next window
    input  logic          windowEnd,
    output logic          accumulating,
    output logic          coarseMode,
    output logic          scanRead,
    output hisPkg::binT   scanAddr,
    output logic          scanLast,
    output logic          clearHist,
    output hisPkg::pixelT pixel,
    output logic          run
);

    hisPkg::hisStateT state;
    hisPkg::hisStateT stateNext;
    hisPkg::binT      lastBin;

    // last scan address depends on the mode of this window
    assign lastBin = coarseMode ? hisPkg::binT'(hisPkg::coarseBins - 1)
                                : hisPkg::binT'(hisPkg::numBins - 1);

    assign accumulating = (state == hisPkg::accum);
    assign run          = accumulating;               // timer follows the window
    assign scanRead     = (state == hisPkg::scan);
    assign scanLast     = scanRead && (scanAddr == lastBin);
    assign clearHist    = (state == hisPkg::clear);

    always_comb begin
        stateNext = state;
        case (state)
            hisPkg::accum: begin
                if (windowEnd) begin
                    stateNext = hisPkg::scan;
                end
            end
            hisPkg::scan: begin
                if (scanLast) begin
                    stateNext = hisPkg::clear;
                end
            end
            hisPkg::clear: begin
                stateNext = hisPkg::accum;      // always a single cycle
            end
            default: begin
                stateNext = hisPkg::accum;
            end
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= hisPkg::accum;
        end else begin
            state <= stateNext;
        end
    end

    // scan address steps only while scanning
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanAddr <= '0;
        end else if (scanRead && !scanLast) begin
            scanAddr <= scanAddr + hisPkg::binT'(1);
        end else begin
            scanAddr <= '0;
        end
    end

    // mode and pixel move on in the clear cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            coarseMode <= 1'b0;         // first window is fine mode
            pixel      <= '0;
        end else if (clearHist) begin
            coarseMode <= coarse;
            pixel      <= pixel + hisPkg::pixelT'(1);   // wraps after 8
        end
    end

endmodule

//--- verilog/binMemory.sv
`timescale 1ns/100ps

module binMemory (
    input  logic              clk,
    input  logic              res,
    input  logic              hit,
    input  hisPkg::binT       hitBin,
    input  logic              accumulating,
    input  logic              coarseMode,
    input  logic              scanRead,
    input  hisPkg::binT       scanAddr,
    input  logic              scanLast,
    input  hisPkg::pixelT     pixel,
    input  logic              clearHist,
    output hisPkg::binReportT binReport,
    output logic              binValid,
    output logic              binLast
);

    hisPkg::countT              counts [hisPkg::numBins];
    logic [hisPkg::numBins-1:0] binOk;       // lazy clear flags

    hisPkg::binT   hitIdx;
    hisPkg::countT hitCount;
    hisPkg::countT newCount;
    logic          doHit;
    hisPkg::countT readCount;

    assign doHit = hit && accumulating;

    // coarse mode merges code pairs by dropping the lsb
    assign hitIdx = coarseMode ? {1'b0, hitBin[4:1]} : hitBin;

    assign hitCount = counts[hitIdx];

    always_comb begin
        if (!binOk[hitIdx]) begin
            newCount = hisPkg::countT'(1);           // first hit since clear
        end else if (hitCount == hisPkg::countT'(hisPkg::countMax)) begin
            newCount = hitCount;                     // saturated
        end else begin
            newCount = hitCount + hisPkg::countT'(1);
        end
    end

    // counter storage, contents only trusted where the flag is set
    always_ff @(posedge clk) begin
        if (doHit) begin
            counts[hitIdx] <= newCount;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binOk <= '0;
        end else if (clearHist) begin
            binOk <= '0;                 // whole histogram cleared at once
        end else if (doHit) begin
            binOk[hitIdx] <= 1'b1;
        end
    end

    // stale bins read back as zero
    assign readCount = binOk[scanAddr] ? counts[scanAddr] : '0;

    always_ff @(posedge clk) begin
        if (scanRead) begin
            binReport.pixel <= pixel;
            binReport.bin   <= scanAddr;
            binReport.count <= readCount;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binValid <= 1'b0;
            binLast  <= 1'b0;
        end else begin
            binValid <= scanRead;        // one cycle behind the read
            binLast  <= scanLast;
        end
    end

endmodule

//--- verilog/peakFinder.sv
`timescale 1ns/100ps

module peakFinder (
    input  logic              clk,
    input  logic              res,
    input  hisPkg::binReportT binReport,
    input  logic              binValid,
    input  logic              binLast,
    output hisPkg::binReportT peakReport,
    output logic              peakValid
);

    hisPkg::binT   bestBin;
    hisPkg::countT bestCount;
    logic          better;

    // strictly greater, so the lower index keeps a tie
    assign better = binReport.count > bestCount;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            bestBin   <= '0;
            bestCount <= '0;
        end else if (binValid && binLast) begin
            bestBin   <= '0;                     // restart for the next scan
            bestCount <= '0;
        end else if (binValid && better) begin
            bestBin   <= binReport.bin;
            bestCount <= binReport.count;
        end
    end

    // last bin still competes in the publishing cycle
    always_ff @(posedge clk) begin
        if (binValid && binLast) begin
            peakReport.pixel <= binReport.pixel;
            peakReport.bin   <= better ? binReport.bin : bestBin;
            peakReport.count <= better ? binReport.count : bestCount;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peakValid <= 1'b0;
        end else begin
            peakValid <= binValid && binLast;     // one cycle pulse
        end
    end

endmodule

//--- verilog/hisBuilder.sv
`timescale 1ns/100ps

module hisBuilder (
    input  logic              clk,
    input  logic              res,
    input  logic              hit,          // one cycle strobe
    input  hisPkg::binT       hitBin,       // time code, valid with hit
    input  logic              coarse,
    output logic              accumulating,
    output hisPkg::binReportT binReport,
    output logic              binValid,
    output hisPkg::binReportT peakReport,
    output logic              peakValid
);

    logic          run;
    logic          windowEnd;
    logic          coarseMode;
    logic          scanRead;
    hisPkg::binT   scanAddr;
    logic          scanLast;
    logic          clearHist;
    hisPkg::pixelT pixel;
    logic          binLast;

    acqTimer i_timer (
        .clk       (clk),
        .res       (res),
        .run       (run),
        .windowEnd (windowEnd)
    );

    hisControl i_control (
        .clk          (clk),
        .res          (res),
        .coarse       (coarse),
        .windowEnd    (windowEnd),
        .accumulating (accumulating),
        .coarseMode   (coarseMode),
        .scanRead     (scanRead),
        .scanAddr     (scanAddr),
        .scanLast     (scanLast),
        .clearHist    (clearHist),
        .pixel        (pixel),
        .run          (run)
    );

    binMemory i_memory (
        .clk          (clk),
        .res          (res),
        .hit          (hit),
        .hitBin       (hitBin),
        .accumulating (accumulating),
        .coarseMode   (coarseMode),
        .scanRead     (scanRead),
        .scanAddr     (scanAddr),
        .scanLast     (scanLast),
        .pixel        (pixel),
        .clearHist    (clearHist),
        .binReport    (binReport),
        .binValid     (binValid),
        .binLast      (binLast)
    );

    peakFinder i_peak (
        .clk        (clk),
        .res        (res),
        .binReport  (binReport),
        .binValid   (binValid),
        .binLast    (binLast),
        .peakReport (peakReport),
        .peakValid  (peakValid)
    );

endmodule

//--- tests/hisBuilderTb.sv
`timescale 1ns/100ps

module hisBuilderTb;

    localparam int resetCycles  = 8;
    localparam int numWindows   = 9;
    localparam int windowCycles = hisPkg::acqCycles + hisPkg::numBins + 4;
    localparam int limitCycles  = (numWindows + 1) * windowCycles + resetCycles;

    // hit patterns for one window
    localparam int kindRandom   = 0;
    localparam int kindNone     = 1;
    localparam int kindSaturate = 2;   // every cycle into bin 5
    localparam int kindAvoid    = 3;   // random, but never code 5

    logic              clk = 1'b0;
    logic              res;
    logic              hit;
    hisPkg::binT       hitBin;
    logic              coarse;
    logic              accumulating;
    hisPkg::binReportT binReport;
    logic              binValid;
    hisPkg::binReportT peakReport;
    logic              peakValid;

    int    seed;
    string testName;
    int    testErrors;
    int    seqErrors;
    int    seqAtStart;
    int    passCount;
    int    failCount;

    hisBuilder i_dut (
        .clk          (clk),
        .res          (res),
        .hit          (hit),
        .hitBin       (hitBin),
        .coarse       (coarse),
        .accumulating (accumulating),
        .binReport    (binReport),
        .binValid     (binValid),
        .peakReport   (peakReport),
        .peakValid    (peakValid)
    );

    always #10 clk = ~clk;   // 20 ns period

    // peak pulse sits right behind the end of the bin stream
    peakAfterStream: assert property (@(posedge clk) disable iff (!res)
        peakValid |-> ($past(binValid) && !binValid))
        else begin
            $display("[ERROR] %s peakValid timing: expected binValid 1 then 0, actual now %0b",
                     testName, binValid);
            seqErrors++;
        end

    task automatic checkValue(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("[ERROR] %s %s: expected %0d, actual %0d", testName, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = 0;
        seqAtStart = seqErrors;
    endtask

    task automatic finishTest();
        int errs;
        errs = testErrors + seqErrors - seqAtStart;
        if (errs == 0) begin
            passCount++;
            $display("%s: ok", testName);
        end else begin
            failCount++;
            $display("%s: %0d errors", testName, errs);
        end
    endtask

    task automatic checkReset();
        int k;
        startTest("resetState");
        for (k = 0; k < resetCycles; k++) begin
            @(negedge clk);
            checkValue("binValid in reset", 0, int'(binValid));
            checkValue("peakValid in reset", 0, int'(peakValid));
        end
        res = 1'b1;
        checkValue("accumulating after reset", 1, int'(accumulating));
        finishTest();
    endtask

    // one pixel: hits while the window is open, then the scan and the peak
    task automatic runWindow(input string name, input int kind, input logic curCoarse,
                             input logic nextCoarse, input int windowIdx);
        hisPkg::countT model [hisPkg::numBins];
        logic [31:0]   r;
        hisPkg::binT   idx;
        hisPkg::binT   peakBin;
        hisPkg::countT peakCount;
        hisPkg::pixelT pix;
        int            nb;
        int            n;
        int            i;
        startTest(name);
        pix = hisPkg::pixelT'(windowIdx);   // wraps like the pixel counter
        nb  = curCoarse ? hisPkg::coarseBins : hisPkg::numBins;
        for (i = 0; i < hisPkg::numBins; i++) begin
            model[hisPkg::binT'(i)] = '0;
        end
        coarse = nextCoarse;   // taken over in the clear cycle
        n = 0;
        while (accumulating) begin
            if (windowIdx == 0 || n > 0) begin
                checkValue("peakValid in accum", 0, int'(peakValid));
            end
            checkValue("binValid in accum", 0, int'(binValid));
            r = $random(seed);
            hitBin = r[5:1];
            case (kind)
                kindRandom:   hit = r[0];
                kindNone:     hit = 1'b0;
                kindSaturate: begin
                    hit    = 1'b1;
                    hitBin = hisPkg::binT'(5);
                end
                default:      hit = r[0] && (r[5:1] != 5'd5);
            endcase
            if (hit) begin
                idx = curCoarse ? (hitBin >> 1) : hitBin;   // code pairs share a bin
                if (model[idx] != hisPkg::countT'(hisPkg::countMax)) begin
                    model[idx] = model[idx] + hisPkg::countT'(1);
                end
            end
            n++;
            @(negedge clk);
        end
        hit = 1'b0;
        checkValue("window length", hisPkg::acqCycles, n);

        while (!binValid) begin
            @(negedge clk);
        end
        i = 0;
        while (binValid) begin
            checkValue("bin index", i, int'(binReport.bin));
            checkValue("bin pixel", int'(pix), int'(binReport.pixel));
            if (i < nb) begin
                checkValue("bin count", int'(model[hisPkg::binT'(i)]), int'(binReport.count));
            end
            i++;
            @(negedge clk);
        end
        checkValue("reports per scan", nb, i);

        // strictly greater keeps the lowest index on a tie
        peakBin   = '0;
        peakCount = '0;
        for (i = 0; i < nb; i++) begin
            if (model[hisPkg::binT'(i)] > peakCount) begin
                peakCount = model[hisPkg::binT'(i)];
                peakBin   = hisPkg::binT'(i);
            end
        end
        checkValue("peakValid", 1, int'(peakValid));
        checkValue("peak bin", int'(peakBin), int'(peakReport.bin));
        checkValue("peak count", int'(peakCount), int'(peakReport.count));
        checkValue("peak pixel", int'(pix), int'(peakReport.pixel));
        finishTest();
    endtask

    initial begin
        seed       = 32'h568e;
        res        = 1'b0;
        hit        = 1'b0;
        hitBin     = '0;
        coarse     = 1'b0;
        testErrors = 0;
        seqErrors  = 0;
        seqAtStart = 0;
        passCount  = 0;
        failCount  = 0;
        checkReset();
        runWindow("fineHist", kindRandom, 1'b0, 1'b0, 0);
        runWindow("emptyPeak", kindNone, 1'b0, 1'b1, 1);
        runWindow("coarseHist", kindRandom, 1'b1, 1'b0, 2);
        runWindow("saturation", kindSaturate, 1'b0, 1'b0, 3);
        runWindow("pixelClear", kindAvoid, 1'b0, 1'b0, 4);
        runWindow("fineRandomA", kindRandom, 1'b0, 1'b1, 5);
        runWindow("coarseRandom", kindRandom, 1'b1, 1'b0, 6);
        runWindow("fineRandomB", kindRandom, 1'b0, 1'b0, 7);
        runWindow("pixelWrap", kindRandom, 1'b0, 1'b0, 8);   // pixel back at 0
        $display("summary: %0d tests ok, %0d tests with errors", passCount, failCount);
        if (failCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog, one spare window on top of all tests
    initial begin
        repeat (limitCycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clock cycles", limitCycles);
        $display("test failed");
        $finish;
    end

endmodule

//--- tb.f
verilog/hisPkg.sv
verilog/acqTimer.sv
verilog/hisControl.sv
verilog/binMemory.sv
verilog/peakFinder.sv
verilog/hisBuilder.sv
tests/hisBuilderTb.sv

//--- runSim.sh
#!/bin/sh
# compile and run the histogram testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module hisBuilderTb -Mdir obj_dir -f tb.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/VhisBuilderTb > sim.log 2>&1
cat sim.log

grep -q "test failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "test passed" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
